//--- dv/fp_div_sqrt_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fp_div_sqrt_tb;

	localparam int NUM_TESTS = 25;
	localparam int RESET_CYCLES = 3;
	localparam int CYCLES_PER_TEST = 48; // Latency plus hold, release and idle gap
	localparam int TIMEOUT_CYCLES = NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES;
	localparam int ACK_DROP_LIMIT = 3;
	localparam logic [31:0] LFSR_SEED = 32'ha951_7a2a;
	localparam fdiv_pkg::fp_op_e DIV = fdiv_pkg::OP_DIV;
	localparam fdiv_pkg::fp_op_e SQRT = fdiv_pkg::OP_SQRT;

	typedef struct packed {
		fdiv_pkg::fp_op_e op;
		fdiv_pkg::fp32_t a;
		fdiv_pkg::fp32_t b;
		logic check_num; // Compare exponent, mantissa and grs too
		fdiv_pkg::div_result_t expected;
	} test_entry_t;

	logic clock;
	logic reset;
	logic req;
	fdiv_pkg::div_request_t request;
	logic ack;
	fdiv_pkg::div_result_t result;

	test_entry_t tests [NUM_TESTS];
	string names [NUM_TESTS];
	int entry_count;
	int error_count;
	int check_count;
	logic [31:0] lfsr_state;

	fp_div_sqrt fp_div_sqrt_inst (
		.clock(clock),
		.reset(reset),
		.req_i(req),
		.request_i(request),
		.ack_o(ack),
		.result_o(result)
	);

	always #4 clock = ~clock;

	// ############################################################
	// Helpers
	// ############################################################

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // Taps 32, 22, 2, 1
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("[ERROR] %0t ns: %s", $time, msg);
	endtask

	task automatic report_mismatch(input int idx, input string field,
			input logic [31:0] got, input logic [31:0] want);
		report_error($sformatf("test %0d (%s) %s is %0h, expected %0h",
			idx, names[idx], field, got, want));
	endtask

	task automatic add_entry(input string name, input fdiv_pkg::fp_op_e op,
			input logic [31:0] a, input logic [31:0] b, input logic check_num,
			input logic sign, input int exponent, input logic [23:0] mantissa,
			input logic [2:0] grs, input logic [4:0] flags);
		test_entry_t e;
		e.op = op;
		e.a = a;
		e.b = b;
		e.check_num = check_num;
		e.expected.sign = sign;
		e.expected.exponent = fdiv_pkg::exp_t'(exponent);
		e.expected.mantissa = mantissa;
		e.expected.grs = grs;
		e.expected.flags = flags;
		tests[entry_count] = e;
		names[entry_count] = name;
		entry_count++;
	endtask

	task automatic check_result(input int idx);
		fdiv_pkg::div_result_t want;
		want = tests[idx].expected;
		check_count++;
		if (result.sign !== want.sign) begin
			report_mismatch(idx, "sign", result.sign, want.sign);
		end
		if (result.flags !== want.flags) begin
			report_mismatch(idx, "flags", result.flags, want.flags);
		end
		if (tests[idx].check_num) begin
			if (result.exponent !== want.exponent) begin
				report_mismatch(idx, "exponent", result.exponent, want.exponent);
			end
			if (result.mantissa !== want.mantissa) begin
				report_mismatch(idx, "mantissa", result.mantissa, want.mantissa);
			end
			if (result.grs !== want.grs) begin
				report_mismatch(idx, "grs", result.grs, want.grs);
			end
		end
	endtask

	task automatic expect_ack(input logic level, input string what);
		check_count++;
		if (ack !== level) begin
			report_error($sformatf("ack_o is %b %s, expected %b", ack, what, level));
		end
	endtask

	task automatic expect_held(input fdiv_pkg::div_result_t held, input string what);
		check_count++;
		if (result !== held) begin
			report_error($sformatf("result_o changed %s: %h, held %h", what, result, held));
		end
	endtask

	// ############################################################
	// Stimulus table
	// ############################################################

	// Flags are invalid, qnan_in, div_zero, inf, zero
	task automatic fill_table();
		add_entry("6.0 / 2.0", DIV, 32'h40c0_0000, 32'h4000_0000, 1'b1,
			1'b0, 128, 24'hc0_0000, 3'b000, 5'b00000);
		add_entry("1.0 / 1.0", DIV, 32'h3f80_0000, 32'h3f80_0000, 1'b1,
			1'b0, 127, 24'h80_0000, 3'b000, 5'b00000);
		add_entry("1.0 / 3.0", DIV, 32'h3f80_0000, 32'h4040_0000, 1'b1,
			1'b0, 125, 24'haa_aaaa, 3'b101, 5'b00000);
		add_entry("-1.0 / 3.0", DIV, 32'hbf80_0000, 32'h4040_0000, 1'b1,
			1'b1, 125, 24'haa_aaaa, 3'b101, 5'b00000);
		add_entry("1.5 / 1.25", DIV, 32'h3fc0_0000, 32'h3fa0_0000, 1'b1,
			1'b0, 127, 24'h99_9999, 3'b101, 5'b00000);
		add_entry("7.0 / -2.0", DIV, 32'h40e0_0000, 32'hc000_0000, 1'b1,
			1'b1, 128, 24'he0_0000, 3'b000, 5'b00000);
		add_entry("sqrt 4.0", SQRT, 32'h4080_0000, 32'h0, 1'b1,
			1'b0, 128, 24'h80_0000, 3'b000, 5'b00000);
		add_entry("sqrt 2.0", SQRT, 32'h4000_0000, 32'h0, 1'b1,
			1'b0, 127, 24'hb5_04f3, 3'b001, 5'b00000);
		add_entry("sqrt 9.0", SQRT, 32'h4110_0000, 32'h0, 1'b1,
			1'b0, 128, 24'hc0_0000, 3'b000, 5'b00000);
		add_entry("sqrt 0.5", SQRT, 32'h3f00_0000, 32'h0, 1'b1,
			1'b0, 126, 24'hb5_04f3, 3'b001, 5'b00000);
		add_entry("sqrt 2^-20", SQRT, 32'h3580_0000, 32'h0, 1'b1,
			1'b0, 117, 24'h80_0000, 3'b000, 5'b00000);
		add_entry("0 / 0", DIV, 32'h0000_0000, 32'h0000_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b10001);
		add_entry("inf / inf", DIV, 32'h7f80_0000, 32'h7f80_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b10001);
		add_entry("snan / 1.0", DIV, 32'h7f80_0001, 32'h3f80_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b10000);
		add_entry("sqrt -1.0", SQRT, 32'hbf80_0000, 32'h0, 1'b0,
			1'b1, 0, 24'h0, 3'b000, 5'b10000);
		add_entry("sqrt -inf", SQRT, 32'hff80_0000, 32'h0, 1'b0,
			1'b1, 0, 24'h0, 3'b000, 5'b10000);
		add_entry("1.0 / 0", DIV, 32'h3f80_0000, 32'h0000_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b00100);
		add_entry("inf / 2.0", DIV, 32'h7f80_0000, 32'h4000_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b00010);
		add_entry("sqrt inf", SQRT, 32'h7f80_0000, 32'h0, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b00010);
		add_entry("0 / 5.0", DIV, 32'h0000_0000, 32'h40a0_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b00001);
		add_entry("5.0 / inf", DIV, 32'h40a0_0000, 32'h7f80_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b00001);
		add_entry("qnan / 1.0", DIV, 32'h7fc0_0000, 32'h3f80_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b01000);
		add_entry("1.0 / qnan", DIV, 32'h3f80_0000, 32'h7fc0_0000, 1'b0,
			1'b0, 0, 24'h0, 3'b000, 5'b01000);
		add_entry("2^-120 / 2^10", DIV, 32'h0380_0000, 32'h4480_0000, 1'b1,
			1'b0, 0, 24'h08_0000, 3'b000, 5'b00000); // Right shift by 4
		add_entry("2^-126 / 2^40", DIV, 32'h0080_0000, 32'h5380_0000, 1'b1,
			1'b0, 0, 24'h00_0000, 3'b010, 5'b00000); // Shift capped
	endtask

	// ############################################################
	// Main sequence
	// ############################################################

	initial begin
		int hold;
		int gap;
		int waited;
		fdiv_pkg::div_result_t held;

		clock = 1'b0;
		reset = 1'b0;
		req = 1'b0;
		request = '0;
		lfsr_state = LFSR_SEED;
		error_count = 0;
		check_count = 0;
		entry_count = 0;
		fill_table();
		if (entry_count != NUM_TESTS) begin
			report_error($sformatf("table holds %0d entries, not %0d", entry_count, NUM_TESTS));
		end

		repeat (RESET_CYCLES - 1) begin
			@(posedge clock);
			@(negedge clock);
			expect_ack(1'b0, "during reset");
		end
		@(posedge clock);
		reset <= 1'b1;
		@(negedge clock);
		expect_ack(1'b0, "after reset");

		for (int t = 0; t < NUM_TESTS; t++) begin
			@(posedge clock);
			req <= 1'b1;
			request <= {tests[t].op, tests[t].a, tests[t].b};
			@(negedge clock);
			while (ack !== 1'b1) begin
				@(negedge clock);
			end
			check_result(t);
			held = result;

			// Back-pressure with req held high
			draw_bits(2, hold);
			for (int i = 0; i < hold; i++) begin
				@(negedge clock);
				expect_ack(1'b1, "while req_i is held");
				expect_held(held, "while req_i is held");
			end

			@(posedge clock);
			req <= 1'b0;
			waited = 0;
			@(negedge clock);
			while (ack === 1'b1 && waited < ACK_DROP_LIMIT) begin
				@(negedge clock);
				waited++;
			end
			expect_ack(1'b0, "after req_i fell");

			draw_bits(3, gap);
			for (int i = 0; i < gap; i++) begin
				@(negedge clock);
				expect_ack(1'b0, "with no request");
				expect_held(held, "with no request");
			end
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- fp_div_sqrt.f
+incdir+source
source/fdiv_pkg.sv
source/operand_unpack.sv
source/digit_recurrence.sv
source/result_normalize.sv
source/fp_div_sqrt.sv
dv/fp_div_sqrt_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the divide and square-root testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module fp_div_sqrt_tb -Mdir obj_dir -f fp_div_sqrt.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vfp_div_sqrt_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF "ALL TESTS PASSED"; then
	exit 0
fi
echo "Simulation reported failure"
exit 1

//--- source/digit_recurrence.sv
`timescale 1ns/1ns
`default_nettype none

`include "fdiv_consts.svh"

module digit_recurrence (
	input wire logic clock,
	input wire logic reset,
	input wire logic start_i,
	input wire fdiv_pkg::rec_init_t init_i,
	output logic done_o,
	output fdiv_pkg::rec_out_t rec_o
);

	logic busy_q;
	logic [4:0] count_q; // Index of the next quotient bit
	fdiv_pkg::fp_op_e op_q;
	fdiv_pkg::rem_t rem_q;
	fdiv_pkg::rem_t divisor_q;
	fdiv_pkg::quot_t quot_q;

	fdiv_pkg::rem_t rem_dbl;
	fdiv_pkg::rem_t trial;
	fdiv_pkg::rem_t diff;

	// ############################################################
	// One restoring step
	// ############################################################

	always_comb begin
		rem_dbl = {rem_q[`FDIV_REM_W-2:0], 1'b0};
		trial = divisor_q;
		if (op_q == fdiv_pkg::OP_SQRT) begin
			trial = {1'b0, quot_q, 1'b0};
			trial[count_q] = 1'b1; // Root so far plus current bit
		end
		diff = rem_dbl - trial;
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			busy_q <= 1'b0;
			count_q <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i) begin
				busy_q <= 1'b1;
				count_q <= (init_i.op == fdiv_pkg::OP_SQRT) ? 5'(`FDIV_SQRT_STEPS - 1)
					: 5'(`FDIV_DIV_STEPS - 1);
			end else if (busy_q) begin
				if (count_q == '0) begin
					busy_q <= 1'b0;
					done_o <= 1'b1;
				end else begin
					count_q <= count_q - 5'd1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start_i) begin
			op_q <= init_i.op;
			rem_q <= init_i.rem;
			divisor_q <= init_i.divisor;
			quot_q <= '0;
		end else if (busy_q) begin
			if (!diff[`FDIV_REM_W-1]) begin // Keep difference when non-negative
				rem_q <= diff;
				quot_q[count_q] <= 1'b1;
			end else begin
				rem_q <= rem_dbl;
			end
		end
	end

	assign rec_o.quot = quot_q;
	assign rec_o.rem = rem_q;

endmodule

`default_nettype wire

//--- source/fdiv_consts.svh
`ifndef FDIV_CONSTS_SVH
`define FDIV_CONSTS_SVH

// ############################################################
// Field widths of the single-precision format
// ############################################################

`define FDIV_FRAC_W 23
`define FDIV_EXP_W 8
`define FDIV_EXP_BIAS 127

// ############################################################
// Recurrence sizing
// ############################################################

`define FDIV_REM_W 28 // Remainder and divisor
`define FDIV_DIV_STEPS 26
`define FDIV_SQRT_STEPS 25

// Largest right shift for results below the normal range
`define FDIV_SHIFT_MAX 25

`endif

//--- source/fdiv_pkg.sv
`default_nettype none

`include "fdiv_consts.svh"

package fdiv_pkg;

	typedef logic [`FDIV_FRAC_W+`FDIV_EXP_W:0] fp32_t;
	typedef logic [`FDIV_FRAC_W:0] mant_t; // With hidden bit
	typedef logic signed [`FDIV_EXP_W+1:0] exp_t;
	typedef logic [`FDIV_REM_W-1:0] rem_t;
	typedef logic [`FDIV_DIV_STEPS-1:0] quot_t;
	typedef logic [2:0] grs_t;

	typedef enum logic {OP_DIV = 1'b0, OP_SQRT = 1'b1} fp_op_e;

	typedef enum logic [1:0] {HS_IDLE, HS_RUN, HS_ACK} hs_state_e;

	typedef struct packed {
		logic invalid;
		logic qnan_in;
		logic div_zero;
		logic inf;
		logic zero;
	} fp_flags_t;

	typedef struct packed {
		fp_op_e op;
		fp32_t a;
		fp32_t b;
	} div_request_t;

	typedef struct packed {
		logic sign;
		exp_t exponent;
		fp_flags_t flags;
		fp_op_e op;
	} unpacked_t;

	typedef struct packed {
		fp_op_e op;
		rem_t rem;
		rem_t divisor;
	} rec_init_t;

	typedef struct packed {
		quot_t quot;
		rem_t rem;
	} rec_out_t;

	typedef struct packed {
		logic sign;
		exp_t exponent;
		mant_t mantissa;
		grs_t grs;
		fp_flags_t flags;
	} div_result_t;

endpackage

`default_nettype wire

//--- source/fp_div_sqrt.sv
`timescale 1ns/1ns
`default_nettype none

module fp_div_sqrt (
	input wire logic clock,
	input wire logic reset,
	input wire logic req_i,
	input wire fdiv_pkg::div_request_t request_i,
	output logic ack_o,
	output fdiv_pkg::div_result_t result_o
);

	fdiv_pkg::hs_state_e state_q;
	logic load;
	logic start_q;
	logic rec_done;
	logic captured_q; // Consumer took the result last edge

	fdiv_pkg::unpacked_t unpacked;
	fdiv_pkg::rec_init_t rec_init;
	fdiv_pkg::rec_out_t rec_out;

	// ############################################################
	// Four-phase handshake FSM
	// ############################################################

	assign load = (state_q == fdiv_pkg::HS_IDLE) && req_i;
	assign ack_o = (state_q == fdiv_pkg::HS_ACK);

	always_ff @(posedge clock) begin
		if (!reset) begin
			state_q <= fdiv_pkg::HS_IDLE;
			start_q <= 1'b0;
			captured_q <= 1'b0;
		end else begin
			start_q <= load;
			captured_q <= rec_done;
			case (state_q)
				fdiv_pkg::HS_IDLE: if (req_i) state_q <= fdiv_pkg::HS_RUN;
				fdiv_pkg::HS_RUN: if (captured_q) state_q <= fdiv_pkg::HS_ACK;
				fdiv_pkg::HS_ACK: if (!req_i) state_q <= fdiv_pkg::HS_IDLE; // Hold until req drops
				default: state_q <= fdiv_pkg::HS_IDLE;
			endcase
		end
	end

	operand_unpack operand_unpack_inst (
		.clock(clock),
		.reset(reset),
		.load_i(load),
		.request_i(request_i),
		.unpacked_o(unpacked),
		.rec_init_o(rec_init)
	);

	digit_recurrence digit_recurrence_inst (
		.clock(clock),
		.reset(reset),
		.start_i(start_q),
		.init_i(rec_init),
		.done_o(rec_done),
		.rec_o(rec_out)
	);

	result_normalize result_normalize_inst (
		.clock(clock),
		.reset(reset),
		.capture_i(rec_done),
		.unpacked_i(unpacked),
		.rec_i(rec_out),
		.result_o(result_o)
	);

endmodule

`default_nettype wire

//--- source/operand_unpack.sv
`timescale 1ns/1ns
`default_nettype none

`include "fdiv_consts.svh"

module operand_unpack (
	input wire logic clock,
	input wire logic reset,
	input wire logic load_i,
	input wire fdiv_pkg::div_request_t request_i,
	output fdiv_pkg::unpacked_t unpacked_o,
	output fdiv_pkg::rec_init_t rec_init_o
);

	localparam fdiv_pkg::fp32_t ONE = 32'h3F80_0000;

	fdiv_pkg::fp32_t opnd [2];
	logic [1:0] is_zero;
	logic [1:0] is_inf;
	logic [1:0] is_snan;
	logic [1:0] is_qnan;
	logic [1:0] is_fin;
	logic is_sqrt;
	fdiv_pkg::fp_flags_t flags;
	fdiv_pkg::exp_t exp_next;
	fdiv_pkg::rec_init_t init_next;

	assign is_sqrt = (request_i.op == fdiv_pkg::OP_SQRT);
	assign opnd[0] = request_i.a;
	assign opnd[1] = is_sqrt ? ONE : request_i.b; // Root divides by +1.0

	// ############################################################
	// Operand classes
	// ############################################################

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			is_fin[i] = ~&opnd[i][30:23];
			is_zero[i] = ~|opnd[i][30:0];
			is_inf[i] = ~is_fin[i] & ~|opnd[i][22:0];
			is_snan[i] = ~is_fin[i] & |opnd[i][22:0] & ~opnd[i][22];
			is_qnan[i] = ~is_fin[i] & opnd[i][22];
		end
	end

	always_comb begin
		flags.invalid = |is_snan
			| (is_zero[0] & is_zero[1])
			| (is_inf[0] & is_inf[1])
			| (is_sqrt & opnd[0][31] & ~is_zero[0] & ~is_snan[0] & ~is_qnan[0]);
		flags.qnan_in = ~flags.invalid & |is_qnan;
		flags.inf = (~is_sqrt & is_inf[0] & is_fin[1])
			| (is_sqrt & is_inf[0] & ~opnd[0][31]);
		flags.div_zero = ~flags.inf & is_zero[1] & is_fin[0] & ~is_zero[0];
		flags.zero = is_zero[0] | is_inf[1];
	end

	// ############################################################
	// Exponent and recurrence start values
	// ############################################################

	always_comb begin
		exp_next = $signed({2'b00, opnd[0][30:23]}) - $signed({2'b00, opnd[1][30:23]});
		init_next.op = request_i.op;
		init_next.rem = {5'b00001, opnd[0][22:0]};
		init_next.divisor = {4'b0001, opnd[1][22:0], 1'b0};
		if (is_sqrt) begin
			// Unbiased halving, odd exponents round up
			exp_next = ($signed({2'b00, opnd[0][30:23]}) - `FDIV_EXP_BIAS + 2) >>> 1;
			init_next.divisor = '0; // Trial value is built per step
			if (!opnd[0][23]) begin
				init_next.rem = {init_next.rem[`FDIV_REM_W-2:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			unpacked_o <= '0;
		end else if (load_i) begin
			unpacked_o.sign <= opnd[0][31] ^ opnd[1][31];
			unpacked_o.exponent <= exp_next;
			unpacked_o.flags <= flags;
			unpacked_o.op <= request_i.op;
		end
	end

	always_ff @(posedge clock) begin
		if (load_i) begin
			rec_init_o <= init_next;
		end
	end

endmodule

`default_nettype wire

//--- source/result_normalize.sv
`timescale 1ns/1ns
`default_nettype none

`include "fdiv_consts.svh"

module result_normalize (
	input wire logic clock,
	input wire logic reset,
	input wire logic capture_i,
	input wire fdiv_pkg::unpacked_t unpacked_i,
	input wire fdiv_pkg::rec_out_t rec_i,
	output fdiv_pkg::div_result_t result_o
);

	localparam int MANT_W = 78; // Quotient, remainder and room for the shift out

	logic [MANT_W-1:0] mant_full;
	logic [MANT_W-1:0] mant_shifted;
	logic lead_zero;
	fdiv_pkg::exp_t exp_biased;
	fdiv_pkg::exp_t exp_final;
	logic [5:0] shift_right;
	fdiv_pkg::div_result_t result_next;

	// ############################################################
	// Normalize and handle underflow
	// ############################################################

	always_comb begin
		mant_full = {rec_i.quot, rec_i.rem[`FDIV_REM_W-2:0], 25'h0};
		lead_zero = ~mant_full[MANT_W-1];
		if (lead_zero) begin
			mant_full = {mant_full[MANT_W-2:0], 1'b0};
		end
		exp_biased = unpacked_i.exponent + `FDIV_EXP_BIAS - $signed({9'h0, lead_zero});

		exp_final = exp_biased;
		shift_right = '0;
		if (exp_biased <= 0) begin
			shift_right = 6'(`FDIV_SHIFT_MAX);
			if (exp_biased > -`FDIV_SHIFT_MAX) begin
				shift_right = 6'(1 - exp_biased);
			end
			exp_final = '0;
		end
		mant_shifted = mant_full >> shift_right;
	end

	always_comb begin
		result_next.sign = unpacked_i.sign;
		result_next.exponent = exp_final;
		result_next.mantissa = mant_shifted[MANT_W-1 -: 24];
		result_next.grs = {mant_shifted[MANT_W-25 -: 2], |mant_shifted[MANT_W-27:0]}; // Sticky
		result_next.flags = unpacked_i.flags;
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			result_o <= '0;
		end else if (capture_i) begin
			result_o <= result_next;
		end
	end

endmodule

`default_nettype wire
